// ==== logic/rv_decode_pkg.sv ====
// ------------------------------
// rv64i decode types; widths are fixed to RV64
// enum encodings start at zero, so a cleared bundle reads as inactive
// ------------------------------
package rv_decode_pkg;

  // data path width
  localparam int XLEN = 64;

  typedef logic [XLEN-1:0] xword_t;
  typedef logic [31:0]     inst_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [5:0]      shamt_t;
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;

  // major opcodes, inst[6:0]
  localparam opcode_t OPC_LUI      = 7'b0110111;
  localparam opcode_t OPC_AUIPC    = 7'b0010111;
  localparam opcode_t OPC_JAL      = 7'b1101111;
  localparam opcode_t OPC_JALR     = 7'b1100111;
  localparam opcode_t OPC_BRANCH   = 7'b1100011;
  localparam opcode_t OPC_LOAD     = 7'b0000011;
  localparam opcode_t OPC_STORE    = 7'b0100011;
  localparam opcode_t OPC_OP_IMM   = 7'b0010011;
  localparam opcode_t OPC_OP       = 7'b0110011;
  localparam opcode_t OPC_OP_IMM_W = 7'b0011011;
  localparam opcode_t OPC_OP_W     = 7'b0111011;

  // alu funct3, same for reg and imm forms
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // branch funct3; 010 and 011 are reserved
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND
  } alu_op_e;

  // always is used by jal and jalr
  typedef enum logic [2:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_ALWAYS
  } br_cond_e;

  typedef enum logic [1:0] {
    MEM_NONE, MEM_LOAD, MEM_STORE
  } mem_act_e;

  // matches funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    MW_BYTE, MW_HALF, MW_WORD, MW_DOUBLE
  } mem_width_e;

  // raw fields of one instruction
  typedef struct packed {
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    funct3_t  funct3;
    logic     f7_bit5;
    opcode_t  opcode;
    xword_t   imm_i;
    xword_t   imm_s;
    xword_t   imm_b;
    xword_t   imm_u;
    xword_t   imm_j;
    shamt_t   shamt;
  } inst_fields_t;

  // decoded class, before operand selection
  typedef struct packed {
    alu_op_e    alu_op;
    br_cond_e   br_cond;
    mem_act_e   mem_act;
    mem_width_e mem_width;
    logic       mem_unsigned;
    logic       is_word;
    logic       rs1_ren;
    logic       rs2_ren;
    logic       rd_wen;
    logic       is_lui;
    logic       is_auipc;
    logic       is_jal;
    logic       is_jalr;
    logic       is_shift_imm;
    logic       illegal;
  } inst_class_t;

  // registered bundle handed to execute
  typedef struct packed {
    alu_op_e    alu_op;
    br_cond_e   br_cond;
    mem_act_e   mem_act;
    mem_width_e mem_width;
    logic       mem_unsigned;
    logic       is_word;
    logic       rs1_ren;
    logic       rs2_ren;
    logic       rd_wen;
    logic       illegal;
    reg_idx_t   rd;
    xword_t     op1;
    xword_t     op2;
    xword_t     op3;
  } dec_bundle_t;

endpackage

// ==== logic/inst_fields.sv ====
// ------------------------------
// pure field slicing, no validity check
// ------------------------------
`timescale 1ns/1ps

module inst_fields (
  input  rv_decode_pkg::inst_t        i_inst,
  output rv_decode_pkg::inst_fields_t o_fields
);

  always_comb begin
    // register indices
    o_fields.rs1     = i_inst[19:15];
    o_fields.rs2     = i_inst[24:20];
    o_fields.rd      = i_inst[11:7];

    // funct bits; only bit 30 of funct7 matters here
    o_fields.funct3  = i_inst[14:12];
    o_fields.f7_bit5 = i_inst[30];
    o_fields.opcode  = i_inst[6:0];

    // i format, inst[31:20]
    o_fields.imm_i = {{(rv_decode_pkg::XLEN-12){i_inst[31]}}, i_inst[31:20]};

    // s format, split around rd slot
    o_fields.imm_s = {{(rv_decode_pkg::XLEN-12){i_inst[31]}},
                      i_inst[31:25],
                      i_inst[11:7]};

    // b format, bit 0 always zero
    o_fields.imm_b = {{(rv_decode_pkg::XLEN-13){i_inst[31]}},
                      i_inst[31],
                      i_inst[7],
                      i_inst[30:25],
                      i_inst[11:8],
                      1'b0};

    // u format, upper 20 bits then sign into 63:32
    o_fields.imm_u = {{(rv_decode_pkg::XLEN-32){i_inst[31]}},
                      i_inst[31:12],
                      12'b0};

    // j format, scrambled 20-bit offset
    o_fields.imm_j = {{(rv_decode_pkg::XLEN-21){i_inst[31]}},
                      i_inst[31],
                      i_inst[19:12],
                      i_inst[20],
                      i_inst[30:21],
                      1'b0};

    // rv64 shift amount is 6 bits, bit 25 included
    o_fields.shamt = i_inst[25:20];
  end

endmodule

// ==== logic/inst_classifier.sv ====
// ------------------------------
// funct7 is checked on bit 30 only; M-extension encodings decode as base ops
// fence, system and csr opcodes decode as illegal
// ------------------------------
`timescale 1ns/1ps

module inst_classifier (
  input  rv_decode_pkg::inst_fields_t i_fields,
  output rv_decode_pkg::inst_class_t  o_class
);

  // funct3 to alu op; alt selects sub or sra
  function automatic rv_decode_pkg::alu_op_e alu_from_f3(
    input rv_decode_pkg::funct3_t f3,
    input logic                   alt
  );
    rv_decode_pkg::alu_op_e op;
    case (f3)
      rv_decode_pkg::F3_ADD:  op = alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
      rv_decode_pkg::F3_SLL:  op = rv_decode_pkg::ALU_SLL;
      rv_decode_pkg::F3_SLT:  op = rv_decode_pkg::ALU_SLT;
      rv_decode_pkg::F3_SLTU: op = rv_decode_pkg::ALU_SLTU;
      rv_decode_pkg::F3_XOR:  op = rv_decode_pkg::ALU_XOR;
      rv_decode_pkg::F3_SR:   op = alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
      rv_decode_pkg::F3_OR:   op = rv_decode_pkg::ALU_OR;
      default:                op = rv_decode_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  rv_decode_pkg::funct3_t     f3;
  logic                       alt;
  logic                       is_sll;
  logic                       is_sr;
  logic                       word_f3_ok;
  logic                       bad;
  rv_decode_pkg::inst_class_t cls;

  assign f3     = i_fields.funct3;
  assign alt    = i_fields.f7_bit5;
  assign is_sll = (f3 == rv_decode_pkg::F3_SLL);
  assign is_sr  = (f3 == rv_decode_pkg::F3_SR);

  // w forms only have add/sub, sll and the right shifts
  assign word_f3_ok = (f3 == rv_decode_pkg::F3_ADD) || is_sll || is_sr;

  always_comb begin
    // all-zero is add, no branch, no memory, no enables
    cls = '0;
    bad = 1'b0;
    case (i_fields.opcode)
      rv_decode_pkg::OPC_LUI: begin
        cls.is_lui = 1'b1;
        cls.rd_wen = 1'b1;
      end
      rv_decode_pkg::OPC_AUIPC: begin
        cls.is_auipc = 1'b1;
        cls.rd_wen   = 1'b1;
      end
      rv_decode_pkg::OPC_JAL: begin
        cls.is_jal  = 1'b1;
        cls.rd_wen  = 1'b1;
        cls.br_cond = rv_decode_pkg::BR_ALWAYS;
      end
      rv_decode_pkg::OPC_JALR: begin
        cls.is_jalr = 1'b1;
        cls.rs1_ren = 1'b1;
        cls.rd_wen  = 1'b1;
        cls.br_cond = rv_decode_pkg::BR_ALWAYS;
        // only funct3 000 defined
        bad = (f3 != rv_decode_pkg::F3_ADD);
      end
      rv_decode_pkg::OPC_BRANCH: begin
        cls.rs1_ren = 1'b1;
        cls.rs2_ren = 1'b1;
        case (f3)
          rv_decode_pkg::F3_BEQ:  cls.br_cond = rv_decode_pkg::BR_EQ;
          rv_decode_pkg::F3_BNE:  cls.br_cond = rv_decode_pkg::BR_NE;
          rv_decode_pkg::F3_BLT:  cls.br_cond = rv_decode_pkg::BR_LT;
          rv_decode_pkg::F3_BGE:  cls.br_cond = rv_decode_pkg::BR_GE;
          rv_decode_pkg::F3_BLTU: cls.br_cond = rv_decode_pkg::BR_LTU;
          rv_decode_pkg::F3_BGEU: cls.br_cond = rv_decode_pkg::BR_GEU;
          default:                bad = 1'b1;
        endcase
      end
      rv_decode_pkg::OPC_LOAD: begin
        cls.rs1_ren      = 1'b1;
        cls.rd_wen       = 1'b1;
        cls.mem_act      = rv_decode_pkg::MEM_LOAD;
        cls.mem_width    = rv_decode_pkg::mem_width_e'(f3[1:0]);
        cls.mem_unsigned = f3[2];
        // no unsigned double load
        bad = (f3 == 3'b111);
      end
      rv_decode_pkg::OPC_STORE: begin
        cls.rs1_ren   = 1'b1;
        cls.rs2_ren   = 1'b1;
        cls.mem_act   = rv_decode_pkg::MEM_STORE;
        cls.mem_width = rv_decode_pkg::mem_width_e'(f3[1:0]);
        bad = f3[2];
      end
      rv_decode_pkg::OPC_OP_IMM: begin
        cls.rs1_ren      = 1'b1;
        cls.rd_wen       = 1'b1;
        // bit 30 is immediate data unless a right shift
        cls.alu_op       = alu_from_f3(f3, alt & is_sr);
        cls.is_shift_imm = is_sll | is_sr;
        bad = is_sll & alt;
      end
      rv_decode_pkg::OPC_OP_IMM_W: begin
        cls.rs1_ren      = 1'b1;
        cls.rd_wen       = 1'b1;
        cls.is_word      = 1'b1;
        cls.alu_op       = alu_from_f3(f3, alt & is_sr);
        cls.is_shift_imm = is_sll | is_sr;
        bad = !word_f3_ok || (is_sll & alt);
      end
      rv_decode_pkg::OPC_OP: begin
        cls.rs1_ren = 1'b1;
        cls.rs2_ren = 1'b1;
        cls.rd_wen  = 1'b1;
        cls.alu_op  = alu_from_f3(f3, alt);
        // alt only valid on add/sub and srl/sra
        bad = alt && !((f3 == rv_decode_pkg::F3_ADD) || is_sr);
      end
      rv_decode_pkg::OPC_OP_W: begin
        cls.rs1_ren = 1'b1;
        cls.rs2_ren = 1'b1;
        cls.rd_wen  = 1'b1;
        cls.is_word = 1'b1;
        cls.alu_op  = alu_from_f3(f3, alt);
        bad = !word_f3_ok || (is_sll & alt);
      end
      default: begin
        bad = 1'b1;
      end
    endcase

    // illegal wipes every side effect
    if (bad) begin
      cls         = '0;
      cls.illegal = 1'b1;
    end
    o_class = cls;
  end

endmodule

// ==== logic/operand_issue.sv ====
// ------------------------------
// one register stage; bundle holds its value on idle cycles
// ------------------------------
`timescale 1ns/1ps

module operand_issue (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        i_ena,
  input  rv_decode_pkg::inst_fields_t i_fields,
  input  rv_decode_pkg::inst_class_t  i_class,
  input  rv_decode_pkg::xword_t       i_pc,
  input  rv_decode_pkg::xword_t       i_rs1_data,
  input  rv_decode_pkg::xword_t       i_rs2_data,
  output logic                        o_valid,
  output rv_decode_pkg::dec_bundle_t  o_dec
);

  logic                       is_branch;
  logic                       is_store;
  logic                       use_rs2;
  rv_decode_pkg::shamt_t      shamt_eff;
  rv_decode_pkg::xword_t      pc_off;
  rv_decode_pkg::xword_t      pc_sum;
  rv_decode_pkg::xword_t      op1_d;
  rv_decode_pkg::xword_t      op2_d;
  rv_decode_pkg::xword_t      op3_d;
  rv_decode_pkg::dec_bundle_t dec_d;

  // conditional branch, not jal/jalr
  assign is_branch = (i_class.br_cond != rv_decode_pkg::BR_NONE) &&
                     (i_class.br_cond != rv_decode_pkg::BR_ALWAYS);
  assign is_store  = (i_class.mem_act == rv_decode_pkg::MEM_STORE);

  // r format and branches compare/operate on rs2
  assign use_rs2 = i_class.rs2_ren && !is_store;

  // w shifts ignore shamt[5]
  assign shamt_eff = i_class.is_word ? {1'b0, i_fields.shamt[4:0]} : i_fields.shamt;

  // shared pc adder: branch target, jal target or link address
  always_comb begin
    if (i_class.is_jal) begin
      pc_off = i_fields.imm_j;
    end else if (is_branch) begin
      pc_off = i_fields.imm_b;
    end else begin
      pc_off = rv_decode_pkg::xword_t'(4);
    end
  end

  assign pc_sum = i_pc + pc_off;

  always_comb begin
    // op1
    if (i_class.illegal) begin
      op1_d = '0;
    end else if (i_class.is_lui || i_class.is_auipc) begin
      op1_d = i_fields.imm_u;
    end else if (i_class.is_jal) begin
      op1_d = i_pc;
    end else begin
      op1_d = i_rs1_data;
    end

    // op2
    if (i_class.illegal || i_class.is_lui) begin
      op2_d = '0;
    end else if (i_class.is_auipc) begin
      op2_d = i_pc;
    end else if (i_class.is_jal) begin
      op2_d = rv_decode_pkg::xword_t'(4);
    end else if (i_class.is_shift_imm) begin
      op2_d = rv_decode_pkg::xword_t'(shamt_eff);
    end else if (is_store) begin
      op2_d = i_fields.imm_s;
    end else if (use_rs2) begin
      op2_d = i_rs2_data;
    end else begin
      // jalr, loads, imm arithmetic
      op2_d = i_fields.imm_i;
    end

    // op3
    if (i_class.illegal) begin
      op3_d = '0;
    end else if (is_branch || i_class.is_jal || i_class.is_jalr) begin
      op3_d = pc_sum;
    end else if (is_store) begin
      op3_d = i_rs2_data;
    end else begin
      op3_d = '0;
    end
  end

  // assemble bundle; rd index zero when not written
  always_comb begin
    dec_d.alu_op       = i_class.alu_op;
    dec_d.br_cond      = i_class.br_cond;
    dec_d.mem_act      = i_class.mem_act;
    dec_d.mem_width    = i_class.mem_width;
    dec_d.mem_unsigned = i_class.mem_unsigned;
    dec_d.is_word      = i_class.is_word;
    dec_d.rs1_ren      = i_class.rs1_ren;
    dec_d.rs2_ren      = i_class.rs2_ren;
    dec_d.rd_wen       = i_class.rd_wen;
    dec_d.illegal      = i_class.illegal;
    dec_d.rd           = i_class.rd_wen ? i_fields.rd : '0;
    dec_d.op1          = op1_d;
    dec_d.op2          = op2_d;
    dec_d.op3          = op3_d;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_valid       <= 1'b0;
      // control fields only, operands keep their value
      o_dec.rd_wen  <= 1'b0;
      o_dec.rs1_ren <= 1'b0;
      o_dec.rs2_ren <= 1'b0;
      o_dec.mem_act <= rv_decode_pkg::MEM_NONE;
      o_dec.br_cond <= rv_decode_pkg::BR_NONE;
      o_dec.illegal <= 1'b0;
    end else begin
      o_valid <= i_ena;
      if (i_ena) begin
        o_dec <= dec_d;
      end
    end
  end

endmodule

// ==== logic/decode_stage.sv ====
// ------------------------------
// read ports are combinational from i_inst, bundle one cycle later
// ------------------------------
`timescale 1ns/1ps

module decode_stage (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       i_ena,
  input  rv_decode_pkg::inst_t       i_inst,
  input  rv_decode_pkg::xword_t      i_pc,
  input  rv_decode_pkg::xword_t      i_rs1_data,
  input  rv_decode_pkg::xword_t      i_rs2_data,
  output rv_decode_pkg::reg_idx_t    o_rs1,
  output rv_decode_pkg::reg_idx_t    o_rs2,
  output logic                       o_rs1_ren,
  output logic                       o_rs2_ren,
  output logic                       o_valid,
  output rv_decode_pkg::dec_bundle_t o_dec
);

  rv_decode_pkg::inst_fields_t fields;
  rv_decode_pkg::inst_class_t  cls;

  // slice fields and immediates
  inst_fields u_fields (
    .i_inst   (i_inst),
    .o_fields (fields)
  );

  // opcode/funct match
  inst_classifier u_classifier (
    .i_fields (fields),
    .o_class  (cls)
  );

  // operand mux and output register
  operand_issue u_issue (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (i_ena),
    .i_fields   (fields),
    .i_class    (cls),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_valid    (o_valid),
    .o_dec      (o_dec)
  );

  // register file read request, index zero when not read
  assign o_rs1_ren = cls.rs1_ren;
  assign o_rs2_ren = cls.rs2_ren;
  assign o_rs1     = cls.rs1_ren ? fields.rs1 : '0;
  assign o_rs2     = cls.rs2_ren ? fields.rs2 : '0;

endmodule

// ==== sim/rv_enc.svh ====
// ------------------------------
// rv64i encoders and decode model for the testbench
// funct7 is judged on bit 30 only, like the decode stage
// ------------------------------
`ifndef RV_ENC_SVH
`define RV_ENC_SVH

// expected read ports plus registered bundle
typedef struct packed {
  rv_decode_pkg::reg_idx_t    rs1;
  rv_decode_pkg::reg_idx_t    rs2;
  logic                       rs1_ren;
  logic                       rs2_ren;
  rv_decode_pkg::dec_bundle_t dec;
} expect_t;

function automatic rv_decode_pkg::inst_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic rv_decode_pkg::inst_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
    input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic rv_decode_pkg::inst_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_decode_pkg::OPC_STORE};
endfunction

// imm[0] is dropped by the format
function automatic rv_decode_pkg::inst_t enc_b(input logic [12:0] imm, input logic [4:0] rs2,
    input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rv_decode_pkg::OPC_BRANCH};
endfunction

function automatic rv_decode_pkg::inst_t enc_u(input logic [19:0] imm, input logic [4:0] rd,
    input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

function automatic rv_decode_pkg::inst_t enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rv_decode_pkg::OPC_JAL};
endfunction

function automatic logic is_kept_opcode(input logic [6:0] opc);
  return opc == rv_decode_pkg::OPC_LUI || opc == rv_decode_pkg::OPC_AUIPC ||
         opc == rv_decode_pkg::OPC_JAL || opc == rv_decode_pkg::OPC_JALR ||
         opc == rv_decode_pkg::OPC_BRANCH || opc == rv_decode_pkg::OPC_LOAD ||
         opc == rv_decode_pkg::OPC_STORE || opc == rv_decode_pkg::OPC_OP_IMM ||
         opc == rv_decode_pkg::OPC_OP || opc == rv_decode_pkg::OPC_OP_IMM_W ||
         opc == rv_decode_pkg::OPC_OP_W;
endfunction

// arithmetic funct3 table from the isa manual
function automatic rv_decode_pkg::alu_op_e alu_for(input logic [2:0] f3, input logic alt);
  case (f3)
    3'd0:    return alt ? rv_decode_pkg::ALU_SUB : rv_decode_pkg::ALU_ADD;
    3'd1:    return rv_decode_pkg::ALU_SLL;
    3'd2:    return rv_decode_pkg::ALU_SLT;
    3'd3:    return rv_decode_pkg::ALU_SLTU;
    3'd4:    return rv_decode_pkg::ALU_XOR;
    3'd5:    return alt ? rv_decode_pkg::ALU_SRA : rv_decode_pkg::ALU_SRL;
    3'd6:    return rv_decode_pkg::ALU_OR;
    default: return rv_decode_pkg::ALU_AND;
  endcase
endfunction

function automatic expect_t expect_decode(input rv_decode_pkg::inst_t inst,
    input rv_decode_pkg::xword_t pc, input rv_decode_pkg::xword_t rs1d,
    input rv_decode_pkg::xword_t rs2d);
  expect_t               e;
  logic [2:0]            f3;
  logic                  alt;
  logic                  ill;
  logic                  word;
  logic                  f3_w_ok;
  rv_decode_pkg::xword_t imm_i;
  rv_decode_pkg::xword_t imm_s;
  rv_decode_pkg::xword_t imm_b;
  rv_decode_pkg::xword_t imm_u;
  rv_decode_pkg::xword_t imm_j;
  e       = '0;
  f3      = inst[14:12];
  alt     = inst[30];
  ill     = 1'b0;
  word    = (inst[6:0] == rv_decode_pkg::OPC_OP_IMM_W) || (inst[6:0] == rv_decode_pkg::OPC_OP_W);
  f3_w_ok = (f3 == 3'd0) || (f3 == 3'd1) || (f3 == 3'd5);
  imm_i   = {{52{inst[31]}}, inst[31:20]};
  imm_s   = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  imm_b   = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  imm_u   = {{32{inst[31]}}, inst[31:12], 12'h000};
  imm_j   = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  case (inst[6:0])
    rv_decode_pkg::OPC_LUI: begin
      e.dec.rd_wen = 1'b1;
      e.dec.op1    = imm_u;
    end
    rv_decode_pkg::OPC_AUIPC: begin
      e.dec.rd_wen = 1'b1;
      e.dec.op1    = imm_u;
      e.dec.op2    = pc;
    end
    rv_decode_pkg::OPC_JAL: begin
      e.dec.rd_wen  = 1'b1;
      e.dec.br_cond = rv_decode_pkg::BR_ALWAYS;
      e.dec.op1     = pc;
      e.dec.op2     = 64'd4;
      e.dec.op3     = pc + imm_j;
    end
    rv_decode_pkg::OPC_JALR: begin
      ill           = (f3 != 3'd0);
      e.dec.rs1_ren = 1'b1;
      e.dec.rd_wen  = 1'b1;
      e.dec.br_cond = rv_decode_pkg::BR_ALWAYS;
      e.dec.op1     = rs1d;
      e.dec.op2     = imm_i;
      e.dec.op3     = pc + 64'd4;
    end
    rv_decode_pkg::OPC_BRANCH: begin
      e.dec.rs1_ren = 1'b1;
      e.dec.rs2_ren = 1'b1;
      e.dec.op1     = rs1d;
      e.dec.op2     = rs2d;
      e.dec.op3     = pc + imm_b;
      case (f3)
        3'd0:    e.dec.br_cond = rv_decode_pkg::BR_EQ;
        3'd1:    e.dec.br_cond = rv_decode_pkg::BR_NE;
        3'd4:    e.dec.br_cond = rv_decode_pkg::BR_LT;
        3'd5:    e.dec.br_cond = rv_decode_pkg::BR_GE;
        3'd6:    e.dec.br_cond = rv_decode_pkg::BR_LTU;
        3'd7:    e.dec.br_cond = rv_decode_pkg::BR_GEU;
        default: ill = 1'b1;
      endcase
    end
    rv_decode_pkg::OPC_LOAD: begin
      ill                = (f3 == 3'd7);
      e.dec.rs1_ren      = 1'b1;
      e.dec.rd_wen       = 1'b1;
      e.dec.mem_act      = rv_decode_pkg::MEM_LOAD;
      e.dec.mem_width    = rv_decode_pkg::mem_width_e'(f3[1:0]);
      e.dec.mem_unsigned = f3[2];
      e.dec.op1          = rs1d;
      e.dec.op2          = imm_i;
    end
    rv_decode_pkg::OPC_STORE: begin
      ill             = f3[2];
      e.dec.rs1_ren   = 1'b1;
      e.dec.rs2_ren   = 1'b1;
      e.dec.mem_act   = rv_decode_pkg::MEM_STORE;
      e.dec.mem_width = rv_decode_pkg::mem_width_e'(f3[1:0]);
      e.dec.op1       = rs1d;
      e.dec.op2       = imm_s;
      e.dec.op3       = rs2d;
    end
    rv_decode_pkg::OPC_OP_IMM, rv_decode_pkg::OPC_OP_IMM_W: begin
      ill           = (f3 == 3'd1 && alt) || (word && !f3_w_ok);
      e.dec.rs1_ren = 1'b1;
      e.dec.rd_wen  = 1'b1;
      e.dec.is_word = word;
      e.dec.alu_op  = alu_for(f3, alt && f3 == 3'd5);
      e.dec.op1     = rs1d;
      // shifts carry shamt, 5 bits for w forms
      if (f3 == 3'd1 || f3 == 3'd5) begin
        e.dec.op2 = word ? {59'd0, inst[24:20]} : {58'd0, inst[25:20]};
      end else begin
        e.dec.op2 = imm_i;
      end
    end
    rv_decode_pkg::OPC_OP, rv_decode_pkg::OPC_OP_W: begin
      if (word) begin
        ill = !f3_w_ok || (f3 == 3'd1 && alt);
      end else begin
        ill = alt && !(f3 == 3'd0 || f3 == 3'd5);
      end
      e.dec.rs1_ren = 1'b1;
      e.dec.rs2_ren = 1'b1;
      e.dec.rd_wen  = 1'b1;
      e.dec.is_word = word;
      e.dec.alu_op  = alu_for(f3, alt);
      e.dec.op1     = rs1d;
      e.dec.op2     = rs2d;
    end
    default: ill = 1'b1;
  endcase
  if (ill) begin
    // nothing survives an illegal encoding
    e             = '0;
    e.dec.illegal = 1'b1;
  end else begin
    e.dec.rd  = e.dec.rd_wen ? inst[11:7] : 5'd0;
    e.rs1_ren = e.dec.rs1_ren;
    e.rs2_ren = e.dec.rs2_ren;
    e.rs1     = e.rs1_ren ? inst[19:15] : 5'd0;
    e.rs2     = e.rs2_ren ? inst[24:20] : 5'd0;
  end
  return e;
endfunction

`endif

// ==== sim/tb_decode_stage.sv ====
// ------------------------------
// random fields, data and pcs from a fixed seed
// ------------------------------
`timescale 1ns/1ps

module tb_decode_stage;

  `include "rv_enc.svh"

  localparam int NUM_ARITH   = 40;
  localparam int NUM_BAD_OPC = 6;
  // 11 memory, 12 branch, 8 jump/upper, 10 fixed illegal
  localparam int NUM_INST    = NUM_ARITH + 11 + 12 + 8 + 10 + NUM_BAD_OPC;
  // reset, idle gaps and margin on top of one cycle per instruction
  localparam int TIMEOUT_NS  = (NUM_INST + 60) * 10;

  logic                       clk = 1'b0;
  logic                       rst;
  logic                       i_ena;
  rv_decode_pkg::inst_t       i_inst;
  rv_decode_pkg::xword_t      i_pc;
  rv_decode_pkg::xword_t      i_rs1_data;
  rv_decode_pkg::xword_t      i_rs2_data;
  rv_decode_pkg::reg_idx_t    o_rs1;
  rv_decode_pkg::reg_idx_t    o_rs2;
  logic                       o_rs1_ren;
  logic                       o_rs2_ren;
  logic                       o_valid;
  rv_decode_pkg::dec_bundle_t o_dec;

  integer                     seed;
  int                         errors = 0;
  string                      test_name;
  string                      name_q;
  expect_t                    exp_now;
  rv_decode_pkg::dec_bundle_t exp_q;
  logic                       valid_q;
  logic                       issued_q;
  logic                       reset_seen = 1'b0;

  decode_stage dut0 (
    .clk        (clk),
    .rst        (rst),
    .i_ena      (i_ena),
    .i_inst     (i_inst),
    .i_pc       (i_pc),
    .i_rs1_data (i_rs1_data),
    .i_rs2_data (i_rs2_data),
    .o_rs1      (o_rs1),
    .o_rs2      (o_rs2),
    .o_rs1_ren  (o_rs1_ren),
    .o_rs2_ren  (o_rs2_ren),
    .o_valid    (o_valid),
    .o_dec      (o_dec)
  );

  always #5 clk = ~clk;

  // model answer for whatever sits on the inputs now
  assign exp_now = expect_decode(i_inst, i_pc, i_rs1_data, i_rs2_data);

  // one-deep delay of the expected bundle held over idle cycles
  always @(posedge clk) begin
    if (rst) begin
      valid_q    <= 1'b0;
      issued_q   <= 1'b0;
      reset_seen <= 1'b1;
    end else begin
      valid_q <= i_ena;
      if (i_ena) begin
        exp_q    <= exp_now.dec;
        name_q   <= test_name;
        issued_q <= 1'b1;
      end
    end
  end

  // sampled at the falling edge where inputs and registers are settled
  always @(negedge clk) begin
    assert (o_rs1_ren === exp_now.rs1_ren && o_rs2_ren === exp_now.rs2_ren &&
            o_rs1 === exp_now.rs1 && o_rs2 === exp_now.rs2) else begin
      errors++;
      $display("ERR %s: read ports exp %b %h %b %h act %b %h %b %h", test_name,
               exp_now.rs1_ren, exp_now.rs1, exp_now.rs2_ren, exp_now.rs2,
               o_rs1_ren, o_rs1, o_rs2_ren, o_rs2);
    end
    if (reset_seen) begin
      assert (o_valid === valid_q) else begin
        errors++;
        $display("ERR %s: o_valid exp %b act %b", name_q, valid_q, o_valid);
      end
      if (issued_q) begin
        assert (o_dec === exp_q) else begin
          errors++;
          $display("ERR %s: bundle exp %h act %h", name_q, exp_q, o_dec);
        end
      end else begin
        assert (o_dec.rd_wen === 1'b0 && o_dec.mem_act === rv_decode_pkg::MEM_NONE) else begin
          errors++;
          $display("bundle still shows a register write or memory action after reset");
        end
      end
    end
  end

  function automatic logic [31:0] next_rand();
    return $random(seed);
  endfunction

  // one enabled cycle with random pc and register data
  task automatic issue(input string name, input rv_decode_pkg::inst_t inst);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;
    logic [31:0] e;
    logic [31:0] f;
    @(posedge clk);
    #1;
    a = next_rand();
    b = next_rand();
    c = next_rand();
    d = next_rand();
    e = next_rand();
    f = next_rand();
    test_name  = name;
    i_ena      = 1'b1;
    i_inst     = inst;
    i_pc       = {a, b[31:2], 2'b00};
    i_rs1_data = {c, d};
    i_rs2_data = {e, f};
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      i_ena = 1'b0;
    end
  endtask

  task automatic run_arith();
    logic [31:0] r;
    logic [31:0] s;
    logic [2:0]  f3;
    logic        alt;
    for (int i = 0; i < NUM_ARITH; i++) begin
      r   = next_rand();
      s   = next_rand();
      f3  = r[4:2];
      alt = r[5];
      case (r[1:0])
        2'd0: begin
          if (f3 != 3'd0 && f3 != 3'd5) begin
            alt = 1'b0;
          end
          issue("op", enc_r({1'b0, alt, 5'd0}, r[20:16], r[15:11], f3, r[10:6],
                rv_decode_pkg::OPC_OP));
        end
        2'd1: begin
          // w forms only have funct3 0, 1 and 5
          f3 = (r[3:2] == 2'd1) ? 3'd1 : (r[3:2] == 2'd2) ? 3'd5 : 3'd0;
          if (f3 == 3'd1) begin
            alt = 1'b0;
          end
          issue("op_w", enc_r({1'b0, alt, 5'd0}, r[20:16], r[15:11], f3, r[10:6],
                rv_decode_pkg::OPC_OP_W));
        end
        2'd2: begin
          if (f3 == 3'd1) begin
            issue("slli", enc_i({6'd0, s[25:20]}, r[15:11], f3, r[10:6],
                  rv_decode_pkg::OPC_OP_IMM));
          end else if (f3 == 3'd5) begin
            issue("srli_srai", enc_i({1'b0, alt, 4'd0, s[25:20]}, r[15:11], f3, r[10:6],
                  rv_decode_pkg::OPC_OP_IMM));
          end else begin
            issue("op_imm", enc_i(s[11:0], r[15:11], f3, r[10:6], rv_decode_pkg::OPC_OP_IMM));
          end
        end
        default: begin
          // shamt bit 5 left random to exercise the w mask
          if (r[3:2] == 2'd1) begin
            issue("slliw", enc_i({6'd0, s[25:20]}, r[15:11], 3'd1, r[10:6],
                  rv_decode_pkg::OPC_OP_IMM_W));
          end else if (r[3:2] == 2'd2) begin
            issue("srliw_sraiw", enc_i({1'b0, alt, 4'd0, s[25:20]}, r[15:11], 3'd5, r[10:6],
                  rv_decode_pkg::OPC_OP_IMM_W));
          end else begin
            issue("addiw", enc_i(s[11:0], r[15:11], 3'd0, r[10:6], rv_decode_pkg::OPC_OP_IMM_W));
          end
        end
      endcase
    end
  endtask

  task automatic run_mem_branch_jump();
    logic [31:0] r;
    logic [2:0]  br_f3 [6];
    br_f3 = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    // every load width and sign then every store width
    for (int k = 0; k < 7; k++) begin
      r = next_rand();
      issue("load", enc_i(r[31:20], r[15:11], k[2:0], r[10:6], rv_decode_pkg::OPC_LOAD));
    end
    for (int k = 0; k < 4; k++) begin
      r = next_rand();
      issue("store", enc_s(r[31:20], r[20:16], r[15:11], k[2:0]));
    end
    idle(1);
    // forward and backward offsets per condition
    for (int k = 0; k < 6; k++) begin
      r = next_rand();
      issue("branch_fwd", enc_b({1'b0, r[31:21], 1'b0}, r[20:16], r[15:11], br_f3[k]));
      issue("branch_back", enc_b({1'b1, r[11:1], 1'b0}, r[20:16], r[15:11], br_f3[k]));
    end
    idle(1);
    for (int k = 0; k < 2; k++) begin
      r = next_rand();
      issue("jal", enc_j({k[0], r[19:1], 1'b0}, r[24:20]));
      issue("jalr", enc_i(r[31:20], r[15:11], 3'd0, r[10:6], rv_decode_pkg::OPC_JALR));
      issue("lui", enc_u({k[0], r[18:0]}, r[24:20], rv_decode_pkg::OPC_LUI));
      issue("auipc", enc_u({k[0], r[30:12]}, r[11:7], rv_decode_pkg::OPC_AUIPC));
    end
  endtask

  task automatic run_illegal();
    logic [31:0] r;
    r = next_rand();
    issue("fence", 32'h0ff0000f);
    issue("ecall", 32'h00000073);
    issue("ebreak", 32'h00100073);
    issue("csrrw", enc_i(12'h300, r[15:11], 3'd1, r[10:6], 7'b1110011));
    issue("branch_f3_2", enc_b(13'h010, r[20:16], r[15:11], 3'd2));
    issue("ldu", enc_i(r[31:20], r[15:11], 3'd7, r[10:6], rv_decode_pkg::OPC_LOAD));
    issue("store_f3_4", enc_s(r[31:20], r[20:16], r[15:11], 3'd4));
    issue("jalr_f3_1", enc_i(r[31:20], r[15:11], 3'd1, r[10:6], rv_decode_pkg::OPC_JALR));
    issue("op_w_f3_2", enc_r(7'd0, r[20:16], r[15:11], 3'd2, r[10:6], rv_decode_pkg::OPC_OP_W));
    issue("slli_bit30", enc_i(12'h405, r[15:11], 3'd1, r[10:6], rv_decode_pkg::OPC_OP_IMM));
    for (int k = 0; k < NUM_BAD_OPC; k++) begin
      r = next_rand();
      while (is_kept_opcode(r[6:0])) begin
        r = next_rand();
      end
      issue("bad_opcode", r);
    end
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("timeout: decode run did not finish within %0d ns", TIMEOUT_NS);
    $display("sim failed");
    $finish;
  end

  initial begin
    seed       = 32'ha383;
    rst        = 1'b1;
    i_ena      = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_rs1_data = '0;
    i_rs2_data = '0;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    rst       = 1'b0;
    test_name = "idle";
    idle(3);
    run_arith();
    idle(2);
    run_mem_branch_jump();
    idle(2);
    run_illegal();
    idle(3);
    $display("decode checks done, errors: %0d", errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== sim.f ====
logic/rv_decode_pkg.sv
logic/inst_fields.sv
logic/inst_classifier.sv
logic/operand_issue.sv
logic/decode_stage.sv
+incdir+sim
sim/tb_decode_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decode stage testbench with verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f sim.f \
  --top-module tb_decode_stage \
  -o tb_decode_stage

./obj_dir/tb_decode_stage | tee sim.log

if grep -q "sim failed" sim.log; then
  echo "decode stage simulation reported failure"
  exit 1
fi
exit 0
